// ==== common/cart_defines.svh ====
// cartridge bus widths and window
`ifndef CART_DEFINES_SVH
`define CART_DEFINES_SVH

// cpu side of the slot
`define CART_ADDR_W 16
`define CART_DATA_W 8

// external cartridge memory address
`define CART_MEM_W 25

// one bank register
`define CART_BANK_W 8

// cartridge window in cpu space, pages 1 and 2
`define CART_WIN_LO 16'h4000
`define CART_WIN_HI 16'hBFFF

`endif

// ==== common/cart_pkg.sv ====
// cartridge shared types
`default_nettype none

`include "cart_defines.svh"

package cart_pkg;

    // cpu address and data
    typedef logic [`CART_ADDR_W-1:0] cpu_addr_t;
    typedef logic [`CART_DATA_W-1:0] cpu_data_t;

    // address into cartridge rom or sram
    typedef logic [`CART_MEM_W-1:0] mem_addr_t;

    // bank register contents
    typedef logic [`CART_BANK_W-1:0] bank_t;

    // mapper codes as delivered by the rom loader
    // unlisted codes fall back to none
    typedef enum logic [5:0] {
        MAPPER_NONE       = 6'd0,
        MAPPER_LINEAR     = 6'd1,
        MAPPER_KONAMI     = 6'd2,
        MAPPER_KONAMI_SCC = 6'd3,
        MAPPER_ASCII8     = 6'd4,
        MAPPER_ASCII16    = 6'd5,
        MAPPER_GM2        = 6'd6
    } mapper_t;

endpackage

`default_nettype wire

// ==== common/cart_bus_if.sv ====
// qualified cpu bus to the mappers
`timescale 1ns/100ps
`default_nettype none

interface cart_bus_if;

    // cpu address and write data, passed straight through
    cart_pkg::cpu_addr_t addr;
    cart_pkg::cpu_data_t d_from_cpu;

    // strobes already qualified by slot, en, mreq and window
    logic                wr_stb;
    logic                rd_stb;

    // decoder forms the strobes
    modport decoder (
        output addr,
        output d_from_cpu,
        output wr_stb,
        output rd_stb
    );

    // mappers only look
    modport mapper (
        input addr,
        input d_from_cpu,
        input wr_stb,
        input rd_stb
    );

endinterface

`default_nettype wire

// ==== src/cart_mapper_decoder.sv ====
// mapper select and strobe qualifier
`timescale 1ns/100ps
`default_nettype none

`include "cart_defines.svh"

module cart_mapper_decoder (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                clk_en,
    input  wire logic                en,
    input  wire logic                slot,
    input  wire logic                mreq,
    input  wire logic                wr,
    input  wire logic                rd,
    input  wire cart_pkg::cpu_addr_t addr,
    input  wire cart_pkg::cpu_data_t d_from_cpu,
    input  wire cart_pkg::mapper_t   mapper,
    cart_bus_if.decoder              bus,
    output logic                     en_none,
    output logic                     en_linear,
    output logic                     en_konami,
    output logic                     en_konami_scc,
    output logic                     en_ascii8,
    output logic                     en_ascii16,
    output logic                     en_gm2
);

    cart_pkg::mapper_t mapper_q;
    logic              in_win;
    logic              mem_cycle;

    // mapper code follows the input only while reset is held
    always_ff @(posedge clk) begin
        if (reset) begin
            mapper_q <= mapper;
        end
    end

    // access falls inside 4000h to bfffh
    assign in_win    = (addr >= `CART_WIN_LO) && (addr <= `CART_WIN_HI);
    assign mem_cycle = en && slot && mreq && in_win;

    // writes land once per clk_en, reads are level
    assign bus.addr       = addr;
    assign bus.d_from_cpu = d_from_cpu;
    assign bus.wr_stb     = mem_cycle && wr && clk_en;
    assign bus.rd_stb     = mem_cycle && rd;

    // exactly one enable, unknown codes count as none
    always_comb begin
        en_none       = 1'b0;
        en_linear     = 1'b0;
        en_konami     = 1'b0;
        en_konami_scc = 1'b0;
        en_ascii8     = 1'b0;
        en_ascii16    = 1'b0;
        en_gm2        = 1'b0;
        case (mapper_q)
            cart_pkg::MAPPER_LINEAR:     en_linear     = 1'b1;
            cart_pkg::MAPPER_KONAMI:     en_konami     = 1'b1;
            cart_pkg::MAPPER_KONAMI_SCC: en_konami_scc = 1'b1;
            cart_pkg::MAPPER_ASCII8:     en_ascii8     = 1'b1;
            cart_pkg::MAPPER_ASCII16:    en_ascii16    = 1'b1;
            cart_pkg::MAPPER_GM2:        en_gm2        = 1'b1;
            default:                     en_none       = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== mappers/cart_konami.sv ====
// konami 8k bank mapper
`timescale 1ns/100ps
`default_nettype none

module cart_konami (
    input  wire logic              clk,
    input  wire logic              reset,
    cart_bus_if.mapper             bus,
    input  wire logic              cs,
    input  wire logic              scc,
    output cart_pkg::mem_addr_t    mem_addr
);

    // one register per 8k page, 4000h 6000h 8000h a000h
    cart_pkg::bank_t bank [4];

    logic [1:0] page;
    logic       plain_hit;
    logic       scc_hit;
    logic       wr_hit;

    // page index from a15..a13
    // 010 -> 0, 011 -> 1, 100 -> 2, 101 -> 3
    assign page = {~bus.addr[14], bus.addr[13]};

    // plain konami, first page is hardwired
    assign plain_hit = (page != 2'd0);

    // scc variant only decodes x000h to x7ffh in the odd 4k
    // i.e. 5000h, 7000h, 9000h, b000h
    assign scc_hit = (bus.addr[12:11] == 2'b10);

    assign wr_hit = scc ? scc_hit : plain_hit;

    // bank registers
    always_ff @(posedge clk) begin
        if (reset) begin
            // power on layout is banks 0..3 in order
            for (int i = 0; i < 4; i++) begin
                bank[i] <= cart_pkg::bank_t'(i);
            end
        end else if (bus.wr_stb && cs && wr_hit) begin
            bank[page] <= bus.d_from_cpu;
        end
    end

    // bank * 8k + offset in page
    // upper bits zero filled
    assign mem_addr = cart_pkg::mem_addr_t'({bank[page], bus.addr[12:0]});

endmodule

`default_nettype wire

// ==== mappers/cart_ascii.sv ====
// ascii8 and ascii16 bank mapper
`timescale 1ns/100ps
`default_nettype none

module cart_ascii (
    input  wire logic              clk,
    input  wire logic              reset,
    cart_bus_if.mapper             bus,
    input  wire logic              cs,
    input  wire logic              mode16,
    output cart_pkg::mem_addr_t    mem_addr
);

    // four 8k slots, 16k mode uses entries 0 and 2
    cart_pkg::bank_t bank [4];

    logic [1:0] wr_sel;
    logic       in_regs;
    logic       wr_hit;
    logic [1:0] rd_sel8;
    logic [1:0] rd_sel16;

    // registers live in 6000h to 7fffh
    assign in_regs = (bus.addr[15:13] == 3'b011);

    // 2k sub range picks the register
    // 6000h 6800h 7000h 7800h
    assign wr_sel = bus.addr[12:11];

    // 16k mode ignores 6800h and 7800h
    assign wr_hit = in_regs && (!mode16 || !bus.addr[11]);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= '0;
            end
        end else if (bus.wr_stb && cs && wr_hit) begin
            bank[wr_sel] <= bus.d_from_cpu;
        end
    end

    // 8k pages
    assign rd_sel8 = {~bus.addr[14], bus.addr[13]};

    // 16k pages
    // 4000h uses entry 0, 8000h uses entry 2
    assign rd_sel16 = {bus.addr[15], 1'b0};

    always_comb begin
        if (mode16) begin
            // bank * 16k + a13..a0
            mem_addr = cart_pkg::mem_addr_t'({bank[rd_sel16], bus.addr[13:0]});
        end else begin
            // bank * 8k + a12..a0
            mem_addr = cart_pkg::mem_addr_t'({bank[rd_sel8], bus.addr[12:0]});
        end
    end

endmodule

`default_nettype wire

// ==== mappers/cart_gamemaster2.sv ====
// game master 2 mapper with sram
`timescale 1ns/100ps
`default_nettype none

module cart_gamemaster2 (
    input  wire logic              clk,
    input  wire logic              reset,
    cart_bus_if.mapper             bus,
    input  wire logic              cs,
    output cart_pkg::mem_addr_t    mem_addr,
    output logic                   sram_oe,
    output logic                   sram_we
);

    // entry 0 stays at bank 0
    cart_pkg::bank_t bank [4];
    logic            sram_sel;
    logic            sram_page;

    logic [1:0] page;
    logic       in_b000;
    logic       sram_area;
    logic       bank_hit;

    assign page    = {~bus.addr[14], bus.addr[13]};
    assign in_b000 = (bus.addr[15:12] == 4'hB);

    // a000h page mapped to sram
    assign sram_area = sram_sel && (page == 2'd3);

    // b000h to bfffh writes go to sram when it is mapped
    assign bank_hit = (page != 2'd0) && !(sram_sel && in_b000);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= '0;
            end
            sram_sel  <= 1'b0;
            sram_page <= 1'b0;
        end else if (bus.wr_stb && cs && bank_hit) begin
            bank[page] <= bus.d_from_cpu;
            // a000h register also carries the sram bits
            if (page == 2'd3) begin
                sram_sel  <= bus.d_from_cpu[4];
                sram_page <= bus.d_from_cpu[5];
            end
        end
    end

    assign sram_oe = cs && bus.rd_stb && sram_area;
    assign sram_we = cs && bus.wr_stb && sram_sel && in_b000;

    // 4k sram pages, otherwise 8k rom banks
    assign mem_addr = sram_area ?
        cart_pkg::mem_addr_t'({sram_page, bus.addr[11:0]}) :
        cart_pkg::mem_addr_t'({bank[page], bus.addr[12:0]});

endmodule

`default_nettype wire

// ==== src/cart_rom.sv ====
// msx cartridge rom mapper top
`timescale 1ns/100ps
`default_nettype none

`include "cart_defines.svh"

module cart_rom (
    input  wire logic                clk,
    input  wire logic                clk_en,
    input  wire logic                reset,
    input  wire cart_pkg::cpu_addr_t addr,
    input  wire logic                wr,
    input  wire logic                rd,
    input  wire logic                mreq,
    input  wire logic                en,
    input  wire logic                slot,
    input  wire cart_pkg::cpu_data_t d_from_cpu,
    input  wire cart_pkg::mapper_t   mapper,
    input  wire logic [3:0]          rom_offset,
    input  wire cart_pkg::mem_addr_t rom_size,
    output cart_pkg::mem_addr_t      mem_addr,
    output logic                     rom_oe,
    output logic                     sram_oe,
    output logic                     sram_we
);

    cart_bus_if bus ();

    cart_pkg::mem_addr_t mem_addr_none, mem_addr_linear, mem_addr_konami;
    cart_pkg::mem_addr_t mem_addr_konami_scc, mem_addr_ascii8, mem_addr_ascii16;
    cart_pkg::mem_addr_t mem_addr_gm2, rom_addr;
    logic en_none, en_linear, en_konami, en_konami_scc, en_ascii8, en_ascii16, en_gm2;
    logic sram_oe_gm2, sram_we_gm2;

    cart_mapper_decoder i_decoder (.*);

    // plain konami and the scc board
    cart_konami i_konami (.clk, .reset, .bus, .cs(en_konami), .scc(1'b0),
                          .mem_addr(mem_addr_konami));
    cart_konami i_konami_scc (.clk, .reset, .bus, .cs(en_konami_scc), .scc(1'b1),
                              .mem_addr(mem_addr_konami_scc));

    // ascii 8k and 16k
    cart_ascii i_ascii8 (.clk, .reset, .bus, .cs(en_ascii8), .mode16(1'b0),
                         .mem_addr(mem_addr_ascii8));
    cart_ascii i_ascii16 (.clk, .reset, .bus, .cs(en_ascii16), .mode16(1'b1),
                          .mem_addr(mem_addr_ascii16));

    cart_gamemaster2 i_gm2 (.clk, .reset, .bus, .cs(en_gm2), .mem_addr(mem_addr_gm2),
                            .sram_oe(sram_oe_gm2), .sram_we(sram_we_gm2));

    // none starts the image at rom_offset * 16k
    assign mem_addr_none = cart_pkg::mem_addr_t'({rom_offset, 14'd0})
                         + cart_pkg::mem_addr_t'(addr - `CART_WIN_LO);

    // linear is the cpu address as is
    assign mem_addr_linear = cart_pkg::mem_addr_t'(addr);

    // enables are one hot, so and-or select
    always_comb begin
        rom_addr = ({$bits(rom_addr){en_none}}       & mem_addr_none)
                 | ({$bits(rom_addr){en_linear}}     & mem_addr_linear)
                 | ({$bits(rom_addr){en_konami}}     & mem_addr_konami)
                 | ({$bits(rom_addr){en_konami_scc}} & mem_addr_konami_scc)
                 | ({$bits(rom_addr){en_ascii8}}     & mem_addr_ascii8)
                 | ({$bits(rom_addr){en_ascii16}}    & mem_addr_ascii16)
                 | ({$bits(rom_addr){en_gm2}}        & mem_addr_gm2);
    end

    // sram cycles bypass the rom size mask
    // rom_size is a power of two
    assign mem_addr = (sram_oe_gm2 || sram_we_gm2) ? mem_addr_gm2 :
                      (rom_addr & (rom_size - 1'b1));

    assign sram_oe = sram_oe_gm2;
    assign sram_we = sram_we_gm2;
    assign rom_oe  = bus.rd_stb && !sram_oe_gm2;

endmodule

`default_nettype wire

// ==== testbench/tb_cart_rom.sv ====
// cartridge rom mapper testbench
`timescale 1ns/100ps
`default_nettype none

`include "cart_defines.svh"

module tb_cart_rom;

    logic                clk;
    logic                clk_en;
    logic                reset;
    cart_pkg::cpu_addr_t addr;
    logic                wr;
    logic                rd;
    logic                mreq;
    logic                en;
    logic                slot;
    cart_pkg::cpu_data_t d_from_cpu;
    cart_pkg::mapper_t   mapper;
    logic [3:0]          rom_offset;
    cart_pkg::mem_addr_t rom_size;
    cart_pkg::mem_addr_t mem_addr;
    logic                rom_oe;
    logic                sram_oe;
    logic                sram_we;

    // expected bank per page, 8k pages or 16k pages for ascii16
    int unsigned bank_model [4];
    int unsigned seed_val;

    cart_rom i_cart_rom (
        .clk(clk),
        .clk_en(clk_en),
        .reset(reset),
        .addr(addr),
        .wr(wr),
        .rd(rd),
        .mreq(mreq),
        .en(en),
        .slot(slot),
        .d_from_cpu(d_from_cpu),
        .mapper(mapper),
        .rom_offset(rom_offset),
        .rom_size(rom_size),
        .mem_addr(mem_addr),
        .rom_oe(rom_oe),
        .sram_oe(sram_oe),
        .sram_we(sram_we)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // one cpu cycle, driven 2 ns after the edge, sampled mid cycle
    task automatic bus_cycle(input logic [15:0] a, input logic [7:0] d, input logic w,
                             input logic r, input logic s, input logic e, input logic ce);
        @(posedge clk);
        #2;
        addr       = a;
        d_from_cpu = d;
        wr         = w;
        rd         = r;
        mreq       = 1'b1;
        slot       = s;
        en         = e;
        clk_en     = ce;
        #16;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        bus_cycle(a, d, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic bus_read(input logic [15:0] a);
        bus_cycle(a, 8'h00, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic set_rom(input logic [3:0] offset, input cart_pkg::mem_addr_t size);
        @(posedge clk);
        #2;
        rom_offset = offset;
        rom_size   = size;
    endtask

    // strobes must drop once the bus is idle
    task automatic wait_idle();
        int n;
        n = 0;
        while ((rom_oe || sram_oe || sram_we) && n < 8) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (rom_oe || sram_oe || sram_we) begin
            fail_now("memory strobes still active 8 cycles after reset");
        end
    endtask

    // mapper code is only taken under reset
    task automatic set_mapper(input logic [5:0] code);
        @(posedge clk);
        #2;
        mapper = cart_pkg::mapper_t'(code);
        reset  = 1'b1;
        mreq   = 1'b0;
        wr     = 1'b0;
        rd     = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        wait_idle();
    endtask

    function automatic logic [15:0] rand_in(input int unsigned base, input int unsigned span);
        return 16'(base + ($urandom % span));
    endfunction

    function automatic logic [31:0] masked(input logic [31:0] a);
        return a & (32'(rom_size) - 32'd1);
    endfunction

    // 8k page p holds bank_model[p]
    task automatic check_page8(input int unsigned p);
        logic [15:0] a;
        a = rand_in(32'h4000 + p * 32'h2000, 32'h2000);
        bus_read(a);
        check("mem_addr", mem_addr, masked(bank_model[p] * 32'h2000 + 32'(a) % 32'h2000));
        check("rom_oe", rom_oe, 32'd1);
        check("sram_oe", sram_oe, 32'd0);
    endtask

    task automatic check_all8();
        for (int p = 0; p < 4; p++) begin
            check_page8(p);
        end
    endtask

    // 16k pages at 4000h and 8000h
    task automatic check_page16(input int unsigned p);
        logic [15:0] a;
        a = rand_in(32'h4000 + p * 32'h4000, 32'h4000);
        bus_read(a);
        check("mem_addr", mem_addr, masked(bank_model[p] * 32'h4000 + 32'(a) % 32'h4000));
        check("rom_oe", rom_oe, 32'd1);
    endtask

    task automatic none_linear_map();
        logic [15:0] a;
        set_mapper(6'd0);
        for (int i = 0; i < 16; i++) begin
            set_rom(4'($urandom), cart_pkg::mem_addr_t'(1) << (14 + $urandom % 11));
            a = rand_in(`CART_WIN_LO, 32'h8000);
            bus_read(a);
            check("mem_addr", mem_addr,
                  masked(32'(rom_offset) * 32'h4000 + 32'(a) - 32'h4000));
            check("rom_oe", rom_oe, 32'd1);
            // no rd, no output enable
            bus_cycle(a, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
            check("rom_oe", rom_oe, 32'd0);
        end
        set_mapper(6'd1);
        for (int i = 0; i < 8; i++) begin
            a = rand_in(`CART_WIN_LO, 32'h8000);
            bus_read(a);
            check("mem_addr", mem_addr, masked(32'(a)));
        end
        // unknown code falls back to none
        set_mapper(6'd9);
        a = rand_in(`CART_WIN_LO, 32'h8000);
        bus_read(a);
        check("mem_addr", mem_addr, masked(32'(rom_offset) * 32'h4000 + 32'(a) - 32'h4000));
        set_rom(4'd0, 25'h1000000);
    endtask

    task automatic konami_banks();
        logic [7:0] v;
        set_mapper(6'd2);
        for (int p = 0; p < 4; p++) begin
            bank_model[p] = p;
        end
        check_all8();
        for (int p = 1; p < 4; p++) begin
            v = 8'($urandom);
            bus_write(rand_in(32'h4000 + p * 32'h2000, 32'h2000), v);
            bank_model[p] = v;
            check_page8(p);
        end
        // first page is fixed
        bus_write(rand_in(32'h4000, 32'h2000), 8'($urandom) | 8'h01);
        check_all8();
    endtask

    task automatic konami_scc_banks();
        logic [7:0] v;
        set_mapper(6'd3);
        for (int p = 0; p < 4; p++) begin
            bank_model[p] = p;
        end
        for (int p = 0; p < 4; p++) begin
            v = 8'($urandom);
            bus_write(rand_in(32'h5000 + p * 32'h2000, 32'h800), v);
            bank_model[p] = v;
            check_all8();
        end
        // 6000h is a plain konami register, not scc
        bus_write(16'h6000, 8'($urandom));
        check_all8();
    endtask

    task automatic ascii_banks();
        logic [7:0] v;
        set_mapper(6'd4);
        bank_model = '{0, 0, 0, 0};
        for (int r = 0; r < 4; r++) begin
            v = 8'($urandom);
            bus_write(rand_in(32'h6000 + r * 32'h800, 32'h800), v);
            bank_model[r] = v;
            check_all8();
        end
        set_mapper(6'd5);
        bank_model = '{0, 0, 0, 0};
        for (int r = 0; r < 2; r++) begin
            v = 8'($urandom);
            bus_write(rand_in(32'h6000 + r * 32'h1000, 32'h800), v);
            bank_model[r] = v;
            check_page16(0);
            check_page16(1);
        end
        // 6800h and 7800h do nothing in 16k mode
        bus_write(rand_in(32'h6800, 32'h800), 8'($urandom));
        bus_write(rand_in(32'h7800, 32'h800), 8'($urandom));
        check_page16(0);
        check_page16(1);
    endtask

    task automatic gm2_sram();
        logic [7:0]  v;
        logic [15:0] a;
        logic        sp;
        set_mapper(6'd6);
        bank_model = '{0, 0, 0, 0};
        for (int p = 1; p < 3; p++) begin
            v = 8'($urandom);
            bus_write(rand_in(32'h4000 + p * 32'h2000, 32'h2000), v);
            bank_model[p] = v;
        end
        // bit 4 maps sram, bit 5 picks the 4k page
        sp = 1'($urandom);
        v  = (8'($urandom) & 8'hCF) | 8'h10 | {2'b00, sp, 5'b00000};
        bus_write(rand_in(32'hA000, 32'h1000), v);
        a = rand_in(32'hA000, 32'h2000);
        bus_read(a);
        check("sram_oe", sram_oe, 32'd1);
        check("rom_oe", rom_oe, 32'd0);
        check("mem_addr", mem_addr, 32'(sp) * 32'h1000 + 32'(a) % 32'h1000);
        // b000h writes hit sram, not a bank register
        // bit 4 clear so a stray bank write would unmap sram
        a = rand_in(32'hB000, 32'h1000);
        bus_write(a, 8'($urandom) & 8'hEF);
        check("sram_we", sram_we, 32'd1);
        check("mem_addr", mem_addr, 32'(sp) * 32'h1000 + 32'(a) % 32'h1000);
        check_page8(0);
        check_page8(1);
        check_page8(2);
        a = rand_in(32'hA000, 32'h2000);
        bus_read(a);
        check("sram_oe", sram_oe, 32'd1);
        check("mem_addr", mem_addr, 32'(sp) * 32'h1000 + 32'(a) % 32'h1000);
        // back to rom in the a000h page
        v = 8'($urandom) & 8'hEF;
        bus_write(rand_in(32'hA000, 32'h1000), v);
        bank_model[3] = v;
        check_page8(3);
    endtask

    task automatic write_qualification();
        logic [7:0] v;
        set_mapper(6'd4);
        bank_model = '{0, 0, 0, 0};
        v = 8'($urandom) | 8'h01;
        // slot low, en low, clk_en low
        bus_cycle(16'h6000, v, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
        check_page8(0);
        bus_cycle(16'h6000, v, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
        check_page8(0);
        bus_cycle(16'h6000, v, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
        check_page8(0);
        bus_cycle(rand_in(32'h4000, 32'h8000), 8'h00, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
        check("rom_oe", rom_oe, 32'd0);
        // fully qualified write still lands
        bus_write(16'h6000, v);
        bank_model[0] = v;
        check_page8(0);
    endtask

    initial begin
        seed_val   = $urandom(75);
        reset      = 1'b1;
        clk_en     = 1'b0;
        addr       = '0;
        wr         = 1'b0;
        rd         = 1'b0;
        mreq       = 1'b0;
        en         = 1'b0;
        slot       = 1'b0;
        d_from_cpu = '0;
        mapper     = cart_pkg::MAPPER_NONE;
        rom_offset = 4'd0;
        rom_size   = 25'h1000000;

        none_linear_map();
        konami_banks();
        konami_scc_banks();
        ascii_banks();
        gm2_sram();
        write_qualification();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/cart_pkg.sv
common/cart_bus_if.sv
src/cart_mapper_decoder.sv
mappers/cart_konami.sv
mappers/cart_ascii.sv
mappers/cart_gamemaster2.sv
src/cart_rom.sv
testbench/tb_cart_rom.sv

// ==== run.sh ====
#!/bin/sh
# build the cart_rom testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_cart_rom -f files.f \
    -o tb_cart_rom_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_cart_rom_sim > sim.log 2>&1
cat sim.log
grep -q "^RESULT: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
